//--- mcu_pwr_params.svh
// ============================================================
// sizing constants for the power sequencer
// domain count, step settling wait, acknowledge sync depth
// ============================================================

`ifndef MCU_PWR_PARAMS_SVH
`define MCU_PWR_PARAMS_SVH

// domain 0 cpu, 1 peripherals, 2 and 3 external
`define MCU_PWR_NUM_DOMAINS 4
`define MCU_PWR_CPU_DOMAIN 0

// settling cycles after each control step
`define MCU_PWR_STEP_CYCLES 4

// flops on the switch acknowledge path
`define MCU_PWR_SYNC_STAGES 2

`endif

//--- mcu_pwr_pkg.sv
// ============================================================
// power step and sequencer state types, interrupt word union
// ============================================================

`default_nettype none

package mcu_pwr_pkg;

  typedef enum logic [1:0] {
    STEP_CLKGATE = 2'd0,
    STEP_ISO     = 2'd1,
    STEP_RST     = 2'd2,
    STEP_SWITCH  = 2'd3
  } pwr_step_e;

  typedef enum logic [3:0] {
    SEQ_IDLE         = 4'd0,
    SEQ_GATE_CLK     = 4'd1,
    SEQ_ISOLATE      = 4'd2,
    SEQ_ASSERT_RST   = 4'd3,
    SEQ_SWITCH_OFF   = 4'd4,
    SEQ_WAIT_OFF_ACK = 4'd5,
    SEQ_SWITCH_ON    = 4'd6,
    SEQ_WAIT_ON_ACK  = 4'd7,
    SEQ_RELEASE_ISO  = 4'd8,
    SEQ_RELEASE_RST  = 4'd9,
    SEQ_UNGATE_CLK   = 4'd10
  } seq_state_e;

  // fast field, bit 14 down to 0:
  // zero, gpio 7..0, spi flash, spi, dma done, timer 3, timer 2, timer 1
  typedef struct packed {
    logic        zero_31;
    logic [14:0] fast;
    logic [3:0]  zero_15_12;
    logic        external;
    logic [2:0]  zero_10_8;
    logic        timer0;
    logic [2:0]  zero_6_4;
    logic        software;
    logic [2:0]  zero_2_0;
  } irq_fields_t;

  typedef union packed {
    logic [31:0] raw;
    irq_fields_t fields;
  } irq_word_u;

endpackage

`default_nettype wire

//--- irq_vector.sv
// ============================================================
// core interrupt word packing and registered wake level
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module irq_vector
  import mcu_pwr_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        irq_software_i,
  input  logic        irq_external_i,
  input  logic [3:0]  timer_intr_i,
  input  logic [7:0]  gpio_intr_i,
  input  logic        spi_flash_intr_i,
  input  logic        spi_intr_i,
  input  logic        dma_done_intr_i,
  output logic [31:0] irq_o,
  output logic        wake_o
);

  irq_word_u irq_w;
  logic      wake_q;

  always_comb begin
    irq_w = '0;
    irq_w.fields.software = irq_software_i;
    irq_w.fields.timer0 = timer_intr_i[0];
    irq_w.fields.external = irq_external_i;
    irq_w.fields.fast = {
      1'b0,
      gpio_intr_i,
      spi_flash_intr_i,
      spi_intr_i,
      dma_done_intr_i,
      timer_intr_i[3],
      timer_intr_i[2],
      timer_intr_i[1]
    };
  end

  assign irq_o = irq_w.raw;

  // any pending source wakes the cpu domain
  always_ff @(posedge clk_i) begin
    if (reset_i) wake_q <= 1'b0;
    else wake_q <= |irq_w.raw;
  end

  assign wake_o = wake_q;

endmodule

`default_nettype wire

//--- ack_sync.sv
// ============================================================
// switch acknowledge synchronizer and expected level compare
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module ack_sync (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [`MCU_PWR_NUM_DOMAINS-1:0]         pwrgate_ack_ni,
  input  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] domain_i,
  input  logic                                    expect_i,
  output logic                                    ack_match_o
);

  // stage 0 samples the pins, last stage is safe to use
  logic [`MCU_PWR_SYNC_STAGES-1:0][`MCU_PWR_NUM_DOMAINS-1:0] sync_q;
  logic                                                       ack_sel;

  // all switches closed out of reset, so acknowledges read low
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`MCU_PWR_SYNC_STAGES-2:0], pwrgate_ack_ni};
    end
  end

  assign ack_sel = sync_q[`MCU_PWR_SYNC_STAGES-1][domain_i];
  assign ack_match_o = (ack_sel == expect_i);

endmodule

`default_nettype wire

//--- step_timer.sv
// ============================================================
// settling wait counter between sequencing steps
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module step_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  output logic done_o
);

  logic [$clog2(`MCU_PWR_STEP_CYCLES+1)-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= ($clog2(`MCU_PWR_STEP_CYCLES+1))'(`MCU_PWR_STEP_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // high in the last counted cycle only
  assign done_o = (cnt_q == 1);

endmodule

`default_nettype wire

//--- domain_ctrl_regs.sv
// ============================================================
// active-low power controls of all gated domains
// clock gate, isolation, reset and switch registers
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module domain_ctrl_regs
  import mcu_pwr_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    step_valid_i,
  input  pwr_step_e                               step_kind_i,
  input  logic                                    step_value_i,
  input  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] domain_i,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         pwrgate_switch_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         iso_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         rst_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         clkgate_en_no
);

  logic [`MCU_PWR_NUM_DOMAINS-1:0] switch_nq;
  logic [`MCU_PWR_NUM_DOMAINS-1:0] iso_nq;
  logic [`MCU_PWR_NUM_DOMAINS-1:0] rst_nq;
  logic [`MCU_PWR_NUM_DOMAINS-1:0] clkgate_nq;

  // every domain powered and running out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_nq <= '0;
      iso_nq <= '1;
      rst_nq <= '1;
      clkgate_nq <= '1;
    end else if (step_valid_i) begin
      case (step_kind_i)
        STEP_CLKGATE: clkgate_nq[domain_i] <= step_value_i;
        STEP_ISO:     iso_nq[domain_i] <= step_value_i;
        STEP_RST:     rst_nq[domain_i] <= step_value_i;
        STEP_SWITCH:  switch_nq[domain_i] <= step_value_i;
        default:      ;
      endcase
    end
  end

  assign pwrgate_switch_no = switch_nq;
  assign iso_no = iso_nq;
  assign rst_no = rst_nq;
  assign clkgate_en_no = clkgate_nq;

endmodule

`default_nettype wire

//--- power_seq_ctrl.sv
// ============================================================
// power sequencer FSM, one domain at a time
// request acceptance, step commands and cpu auto wake
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module power_seq_ctrl
  import mcu_pwr_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    pwr_down_i,
  input  logic                                    pwr_up_i,
  input  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] pwr_domain_i,
  input  logic                                    core_sleep_i,
  input  logic                                    wake_i,
  input  logic                                    timer_done_i,
  input  logic                                    ack_match_i,
  output logic                                    step_valid_o,
  output pwr_step_e                               step_kind_o,
  output logic                                    step_value_o,
  output logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] domain_o,
  output logic                                    timer_start_o,
  output logic                                    ack_expect_o
);

  seq_state_e                              state_q, state_d;
  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] dom_q, dom_d;
  logic [`MCU_PWR_NUM_DOMAINS-1:0]         dom_on_q;
  logic                                    enter_step;
  logic                                    cpu_wake;
  logic                                    down_ok;
  logic                                    up_ok;

  assign cpu_wake = wake_i && !dom_on_q[`MCU_PWR_CPU_DOMAIN];
  // cpu may only go down while the core sleeps
  assign down_ok = pwr_down_i && dom_on_q[pwr_domain_i] &&
                   (core_sleep_i || pwr_domain_i != `MCU_PWR_CPU_DOMAIN);
  assign up_ok = pwr_up_i && !dom_on_q[pwr_domain_i];

  always_comb begin
    state_d = state_q;
    dom_d = dom_q;
    case (state_q)
      SEQ_IDLE: begin
        if (cpu_wake) begin
          state_d = SEQ_SWITCH_ON;
          dom_d = ($clog2(`MCU_PWR_NUM_DOMAINS))'(`MCU_PWR_CPU_DOMAIN);
        end else if (down_ok) begin
          state_d = SEQ_GATE_CLK;
          dom_d = pwr_domain_i;
        end else if (up_ok) begin
          state_d = SEQ_SWITCH_ON;
          dom_d = pwr_domain_i;
        end
      end
      SEQ_GATE_CLK:     if (timer_done_i) state_d = SEQ_ISOLATE;
      SEQ_ISOLATE:      if (timer_done_i) state_d = SEQ_ASSERT_RST;
      SEQ_ASSERT_RST:   if (timer_done_i) state_d = SEQ_SWITCH_OFF;
      SEQ_SWITCH_OFF:   if (timer_done_i) state_d = SEQ_WAIT_OFF_ACK;
      SEQ_WAIT_OFF_ACK: if (ack_match_i) state_d = SEQ_IDLE;
      SEQ_SWITCH_ON:    if (timer_done_i) state_d = SEQ_WAIT_ON_ACK;
      SEQ_WAIT_ON_ACK:  if (ack_match_i) state_d = SEQ_RELEASE_ISO;
      SEQ_RELEASE_ISO:  if (timer_done_i) state_d = SEQ_RELEASE_RST;
      SEQ_RELEASE_RST:  if (timer_done_i) state_d = SEQ_UNGATE_CLK;
      SEQ_UNGATE_CLK:   if (timer_done_i) state_d = SEQ_IDLE;
      default:          state_d = SEQ_IDLE;
    endcase
  end

  // one command on the transition into each step state
  assign enter_step = (state_d != state_q) &&
                      !(state_d inside {SEQ_IDLE, SEQ_WAIT_OFF_ACK, SEQ_WAIT_ON_ACK});

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SEQ_IDLE;
      dom_q <= '0;
      dom_on_q <= '1;
    end else begin
      state_q <= state_d;
      dom_q <= dom_d;
      if (state_q == SEQ_WAIT_OFF_ACK && ack_match_i) dom_on_q[dom_q] <= 1'b0;
      if (state_q == SEQ_UNGATE_CLK && timer_done_i) dom_on_q[dom_q] <= 1'b1;
    end
  end

  always_comb begin
    step_kind_o = STEP_CLKGATE;
    step_value_o = 1'b0;
    case (state_d)
      SEQ_ISOLATE:     step_kind_o = STEP_ISO;
      SEQ_ASSERT_RST:  step_kind_o = STEP_RST;
      SEQ_SWITCH_OFF: begin
        step_kind_o = STEP_SWITCH;
        step_value_o = 1'b1;
      end
      SEQ_SWITCH_ON:   step_kind_o = STEP_SWITCH;
      SEQ_RELEASE_ISO: begin
        step_kind_o = STEP_ISO;
        step_value_o = 1'b1;
      end
      SEQ_RELEASE_RST: begin
        step_kind_o = STEP_RST;
        step_value_o = 1'b1;
      end
      SEQ_UNGATE_CLK:  step_value_o = 1'b1;
      default:         ;
    endcase
  end

  assign step_valid_o = enter_step;
  assign timer_start_o = enter_step;
  assign domain_o = dom_d;
  // switch open reads back as a high acknowledge
  assign ack_expect_o = (state_q == SEQ_WAIT_OFF_ACK);

endmodule

`default_nettype wire

//--- mcu_power_top.sv
// ============================================================
// power control and interrupt assembly top level
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module mcu_power_top
  import mcu_pwr_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    core_sleep_i,
  input  logic                                    pwr_down_i,
  input  logic                                    pwr_up_i,
  input  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] pwr_domain_i,
  input  logic                                    irq_software_i,
  input  logic                                    irq_external_i,
  input  logic [3:0]                              timer_intr_i,
  input  logic [7:0]                              gpio_intr_i,
  input  logic                                    spi_flash_intr_i,
  input  logic                                    spi_intr_i,
  input  logic                                    dma_done_intr_i,
  input  logic [`MCU_PWR_NUM_DOMAINS-1:0]         pwrgate_ack_ni,
  output logic [31:0]                             irq_o,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         pwrgate_switch_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         iso_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         rst_no,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0]         clkgate_en_no
);

  logic                                    wake;
  logic                                    step_valid;
  pwr_step_e                               step_kind;
  logic                                    step_value;
  logic [$clog2(`MCU_PWR_NUM_DOMAINS)-1:0] seq_domain;
  logic                                    timer_start;
  logic                                    timer_done;
  logic                                    ack_expect;
  logic                                    ack_match;

  irq_vector i_irq_vector (
    .clk_i,
    .reset_i,
    .irq_software_i,
    .irq_external_i,
    .timer_intr_i,
    .gpio_intr_i,
    .spi_flash_intr_i,
    .spi_intr_i,
    .dma_done_intr_i,
    .irq_o,
    .wake_o(wake)
  );

  power_seq_ctrl i_power_seq_ctrl (
    .clk_i,
    .reset_i,
    .pwr_down_i,
    .pwr_up_i,
    .pwr_domain_i,
    .core_sleep_i,
    .wake_i(wake),
    .timer_done_i(timer_done),
    .ack_match_i(ack_match),
    .step_valid_o(step_valid),
    .step_kind_o(step_kind),
    .step_value_o(step_value),
    .domain_o(seq_domain),
    .timer_start_o(timer_start),
    .ack_expect_o(ack_expect)
  );

  step_timer i_step_timer (
    .clk_i,
    .reset_i,
    .start_i(timer_start),
    .done_o(timer_done)
  );

  ack_sync i_ack_sync (
    .clk_i,
    .reset_i,
    .pwrgate_ack_ni,
    .domain_i(seq_domain),
    .expect_i(ack_expect),
    .ack_match_o(ack_match)
  );

  domain_ctrl_regs i_domain_ctrl_regs (
    .clk_i,
    .reset_i,
    .step_valid_i(step_valid),
    .step_kind_i(step_kind),
    .step_value_i(step_value),
    .domain_i(seq_domain),
    .pwrgate_switch_no,
    .iso_no,
    .rst_no,
    .clkgate_en_no
  );

endmodule

`default_nettype wire

//--- tb_switch_model.sv
// ============================================================
// behavioral power-switch cells with random acknowledge delay
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module tb_switch_model (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [`MCU_PWR_NUM_DOMAINS-1:0] switch_ni,
  output logic [`MCU_PWR_NUM_DOMAINS-1:0] ack_no
);

  logic [`MCU_PWR_NUM_DOMAINS-1:0] ack_q = '0;
  logic [2:0]                      delay_q [`MCU_PWR_NUM_DOMAINS];

  // ack follows the switch control 1 to 6 cycles after a change is seen
  always @(posedge clk_i) begin
    for (int d = 0; d < `MCU_PWR_NUM_DOMAINS; d++) begin
      if (reset_i) begin
        ack_q[d] <= 1'b0;
        delay_q[d] <= 3'd0;
      end else if (ack_q[d] == switch_ni[d]) begin
        delay_q[d] <= 3'd0;
      end else if (delay_q[d] == 3'd0) begin
        delay_q[d] <= 3'($urandom_range(6, 1));
      end else if (delay_q[d] == 3'd1) begin
        ack_q[d] <= switch_ni[d];
      end else begin
        delay_q[d] <= delay_q[d] - 3'd1;
      end
    end
  end

  assign ack_no = ack_q;

endmodule

`default_nettype wire

//--- tb_mcu_power.sv
// ============================================================
// testbench for the power control and interrupt assembly top
// reference models, output compare, sequence stimulus, timeout
// ============================================================

`timescale 1ns/1ps
`default_nettype none

`include "mcu_pwr_params.svh"

module tb_mcu_power;

  localparam int ND = `MCU_PWR_NUM_DOMAINS;
  localparam int NUM_SEQUENCES = 10;
  localparam int SEQ_CYCLES = 5 * (`MCU_PWR_STEP_CYCLES + 1) + 2 * (6 + `MCU_PWR_SYNC_STAGES);
  localparam int CYCLE_LIMIT = NUM_SEQUENCES * SEQ_CYCLES + 200;

  logic        clk;
  logic        reset;
  logic        core_sleep;
  logic        pwr_down;
  logic        pwr_up;
  logic [1:0]  pwr_domain;
  // software, external, timer 3..0, gpio 7..0, spi flash, spi, dma done
  logic [16:0] irq_src;
  logic [31:0] irq;
  logic [ND-1:0] ack_n;
  logic [ND-1:0] switch_n;
  logic [ND-1:0] iso_n;
  logic [ND-1:0] rst_n;
  logic [ND-1:0] clkgate_n;

  // per domain position, 0 on, 1..4 down steps, 5..7 up steps
  logic [ND-1:0][2:0] dom_pos = '0;
  logic               active_valid = 1'b0;
  logic [1:0]         active_dom = 2'd0;
  logic               active_down = 1'b0;
  logic               req_seen = 1'b0;
  int req_cycle = 0;
  int cycle_count = 0;
  int last_change = -100;
  int value_errors = 0;
  int timing_errors = 0;
  int seq_errors = 0;

  mcu_power_top i_dut (
    .clk_i(clk),
    .reset_i(reset),
    .core_sleep_i(core_sleep),
    .pwr_down_i(pwr_down),
    .pwr_up_i(pwr_up),
    .pwr_domain_i(pwr_domain),
    .irq_software_i(irq_src[0]),
    .irq_external_i(irq_src[1]),
    .timer_intr_i(irq_src[5:2]),
    .gpio_intr_i(irq_src[13:6]),
    .spi_flash_intr_i(irq_src[14]),
    .spi_intr_i(irq_src[15]),
    .dma_done_intr_i(irq_src[16]),
    .pwrgate_ack_ni(ack_n),
    .irq_o(irq),
    .pwrgate_switch_no(switch_n),
    .iso_no(iso_n),
    .rst_no(rst_n),
    .clkgate_en_no(clkgate_n)
  );

  tb_switch_model i_switch_model (
    .clk_i(clk),
    .reset_i(reset),
    .switch_ni(switch_n),
    .ack_no(ack_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] expected_irq(input logic [16:0] src);
    logic [31:0] word;
    word = '0;
    word[3] = src[0];
    word[7] = src[2];
    word[11] = src[1];
    // fast field from bit 16: timer 1..3, dma, spi, spi flash, gpio 0..7
    word[18:16] = src[5:3];
    word[19] = src[16];
    word[20] = src[15];
    word[21] = src[14];
    word[29:22] = src[13:6];
    return word;
  endfunction

  function automatic logic [4*ND-1:0] expected_ctrl(input logic [ND-1:0][2:0] pos);
    logic [ND-1:0] sw;
    logic [ND-1:0] iso;
    logic [ND-1:0] rst;
    logic [ND-1:0] clk_en;
    for (int d = 0; d < ND; d++) begin
      sw[d] = (pos[d] == 3'd4);
      iso[d] = pos[d] inside {3'd0, 3'd1, 3'd6, 3'd7};
      rst[d] = pos[d] inside {3'd0, 3'd1, 3'd2, 3'd7};
      clk_en[d] = (pos[d] == 3'd0);
    end
    return {sw, iso, rst, clk_en};
  endfunction

  // up steps wrap from 7 back to 0
  function automatic logic [2:0] next_position(input logic [2:0] p, input logic down);
    if (down && p < 3'd4) return p + 3'd1;
    if (!down && p >= 3'd4) return p + 3'd1;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h, cycle %0d", name, actual, expected,
               cycle_count);
    end
  endtask

  always @(posedge clk) begin : compare_outputs
    logic [4*ND-1:0]    actual;
    logic [4*ND-1:0]    expected;
    logic [ND-1:0][2:0] advanced;
    if (!reset) begin
      check_value("irq_o", irq, expected_irq(irq_src));
      // strobe for the sequence under test, first step must follow one cycle later
      if ((pwr_down || pwr_up) && active_valid && pwr_domain == active_dom) begin
        req_cycle = cycle_count;
        req_seen = 1'b1;
      end
      actual = {switch_n, iso_n, rst_n, clkgate_n};
      expected = expected_ctrl(dom_pos);
      advanced = dom_pos;
      if (active_valid) begin
        advanced[active_dom] = next_position(dom_pos[active_dom], active_down);
      end
      if (actual !== expected) begin
        if (active_valid && actual === expected_ctrl(advanced)) begin
          if (cycle_count - last_change < `MCU_PWR_STEP_CYCLES) begin
            timing_errors++;
            $display("domain %0d stepped only %0d cycles after its previous step",
                     active_dom, cycle_count - last_change);
          end
          if (req_seen && cycle_count - req_cycle != 1) begin
            timing_errors++;
            $display("domain %0d took its first step %0d cycles after the request",
                     active_dom, cycle_count - req_cycle);
          end
          if (advanced[active_dom] == 3'd6 && ack_n[active_dom] !== 1'b0) begin
            seq_errors++;
            $display("domain %0d released isolation before its switch acknowledged",
                     active_dom);
          end
          req_seen = 1'b0;
          dom_pos = advanced;
          last_change = cycle_count;
        end else begin
          check_value("pwrgate_switch_no", 32'(actual[4*ND-1:3*ND]),
                      32'(expected[4*ND-1:3*ND]));
          check_value("iso_no", 32'(actual[3*ND-1:2*ND]), 32'(expected[3*ND-1:2*ND]));
          check_value("rst_no", 32'(actual[2*ND-1:ND]), 32'(expected[2*ND-1:ND]));
          check_value("clkgate_en_no", 32'(actual[ND-1:0]), 32'(expected[ND-1:0]));
        end
      end
    end
  end

  task automatic pulse_request(input logic [1:0] dom, input logic down);
    @(negedge clk);
    pwr_domain = dom;
    pwr_down = down;
    pwr_up = !down;
    @(negedge clk);
    pwr_down = 1'b0;
    pwr_up = 1'b0;
  endtask

  task automatic start_sequence(input logic [1:0] dom, input logic down);
    @(negedge clk);
    active_dom = dom;
    active_down = down;
    active_valid = 1'b1;
    pulse_request(dom, down);
  endtask

  task automatic finish_sequence(input logic [1:0] dom, input logic down);
    int         waited;
    logic [2:0] target;
    target = down ? 3'd4 : 3'd0;
    waited = 0;
    while (dom_pos[dom] != target && waited < SEQ_CYCLES + 20) begin
      @(negedge clk);
      waited++;
    end
    if (dom_pos[dom] != target) begin
      seq_errors++;
      $display("domain %0d did not complete its power-%s sequence", dom, down ? "down" : "up");
    end
    // let the sequencer get back to idle
    waited = 0;
    while (down && ack_n[dom] !== 1'b1 && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    repeat (`MCU_PWR_STEP_CYCLES + `MCU_PWR_SYNC_STAGES + 3) @(negedge clk);
    active_valid = 1'b0;
  endtask

  task automatic run_sequence(input logic [1:0] dom, input logic down);
    start_sequence(dom, down);
    finish_sequence(dom, down);
  endtask

  // any control change seen here is reported by the compare process
  task automatic expect_ignored(input logic [1:0] dom, input logic down);
    pulse_request(dom, down);
    repeat (12) @(negedge clk);
  endtask

  initial begin : stimulus
    logic [4:0] wake_src;
    void'($urandom(90524));
    reset = 1'b1;
    core_sleep = 1'b0;
    pwr_down = 1'b0;
    pwr_up = 1'b0;
    pwr_domain = 2'd0;
    irq_src = '0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);
    repeat (32) begin
      @(negedge clk);
      irq_src = 17'($urandom);
    end
    @(negedge clk);
    irq_src = '0;
    for (int d = 1; d < ND; d++) run_sequence(2'(d), 1'b1);
    for (int d = 1; d < ND; d++) run_sequence(2'(d), 1'b0);
    // cpu awake, then a domain already on
    expect_ignored(2'd0, 1'b1);
    expect_ignored(2'd3, 1'b0);
    // second request while domain 2 is sequencing
    start_sequence(2'd2, 1'b1);
    repeat (3) @(negedge clk);
    pulse_request(2'd3, 1'b1);
    finish_sequence(2'd2, 1'b1);
    expect_ignored(2'd2, 1'b1);
    run_sequence(2'd2, 1'b0);
    core_sleep = 1'b1;
    run_sequence(2'd0, 1'b1);
    expect_ignored(2'd0, 1'b1);
    // one pending interrupt wakes the cpu domain
    @(negedge clk);
    active_dom = 2'd0;
    active_down = 1'b0;
    active_valid = 1'b1;
    wake_src = 5'($urandom_range(16, 0));
    irq_src[wake_src] = 1'b1;
    finish_sequence(2'd0, 1'b0);
    irq_src = '0;
    core_sleep = 1'b0;
    repeat (4) @(negedge clk);
    $display("errors: %0d value, %0d timing, %0d sequence", value_errors, timing_errors,
             seq_errors);
    if (value_errors + timing_errors + seq_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  always @(negedge clk) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("errors: %0d value, %0d timing, %0d sequence", value_errors, timing_errors,
               seq_errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
mcu_pwr_pkg.sv
irq_vector.sv
ack_sync.sv
step_timer.sv
domain_ctrl_regs.sv
power_seq_ctrl.sv
mcu_power_top.sv
tb_switch_model.sv
tb_mcu_power.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_mcu_power -o sim_mcu_power
./obj_dir/sim_mcu_power | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
